//--- iq_pkg.sv
package iq_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int WORD_W = 32;  // operand and immediate
    localparam int PC_W   = 32;
    localparam int OP_W   = 6;
    localparam int TAG_W  = 4;   // 16-deep reorder buffer

    // defaults for the top level
    localparam int DEFAULT_DEPTH  = 4;
    localparam int DEFAULT_NUM_WB = 3;

    // ----------------------------------------------------------
    // structs
    // ----------------------------------------------------------

    // per-instruction fields that never change while queued
    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic [PC_W-1:0]   pc;
        logic [WORD_W-1:0] imm;
        logic [TAG_W-1:0]  dst;    // allocated rob entry
    } payload_t;

    // one source operand
    // pending set means value is not there yet, wait for tag
    typedef struct packed {
        logic              pending;
        logic [TAG_W-1:0]  tag;
        logic [WORD_W-1:0] value;
    } src_t;

    // writeback broadcast
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [WORD_W-1:0] data;
    } wb_bus_t;

    // what goes to the functional unit
    typedef struct packed {
        payload_t          payload;
        logic [WORD_W-1:0] rs1_value;
        logic [WORD_W-1:0] rs2_value;
    } issue_t;

endpackage

//--- iq_occupancy.sv
`timescale 1ns/100ps

module iq_occupancy #(
    parameter int DEPTH = iq_pkg::DEFAULT_DEPTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             dispatch_valid,
    input  logic             flush,
    input  logic             fu_ready,
    input  logic             head_pending_rs1,
    input  logic             head_pending_rs2,
    output logic [DEPTH:0]   fill_ptr,
    output logic [DEPTH-1:0] entry_valid,
    output logic             write_en,
    output logic             shift,
    output logic             full
);

    // ----------------------------------------------------------
    // validity from the fill pointer
    // ----------------------------------------------------------

    // slot i holds an entry when the pointer sits above it
    for (genvar i = 0; i < DEPTH; i++) begin : g_valid
        assign entry_valid[i] = ~|fill_ptr[i:0];
    end

    assign full = fill_ptr[DEPTH];

    // ----------------------------------------------------------
    // write and issue decisions
    // ----------------------------------------------------------

    // dispatch into a full queue is simply lost
    assign write_en = dispatch_valid && !full && !flush;

    // head only, both operands in, unit can take it
    assign shift = entry_valid[0] && !head_pending_rs1 && !head_pending_rs2
                   && fu_ready && !flush;

    // ----------------------------------------------------------
    // one-hot pointer, bit 0 is empty, bit DEPTH is full
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_ptr <= {{DEPTH{1'b0}}, 1'b1};
        end else if (flush) begin
            fill_ptr <= {{DEPTH{1'b0}}, 1'b1};  // drop everything
        end else if (write_en && !shift) begin
            fill_ptr <= fill_ptr << 1;
        end else if (shift && !write_en) begin
            fill_ptr <= fill_ptr >> 1;
        end
        // write with issue keeps the count
    end

endmodule

//--- iq_payload_column.sv
`timescale 1ns/100ps

module iq_payload_column #(
    parameter int DEPTH = iq_pkg::DEFAULT_DEPTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             write_en,
    input  logic             shift,
    input  logic [DEPTH:0]   fill_ptr,
    input  iq_pkg::payload_t dispatch_payload,
    output iq_pkg::payload_t head_payload
);

    import iq_pkg::*;

    // ----------------------------------------------------------
    // storage, slot 0 is the oldest
    // ----------------------------------------------------------
    payload_t slot_q [DEPTH];

    logic [DEPTH-1:0] load_sel;   // slot that takes the dispatch
    logic [DEPTH-1:0] move_sel;   // slot that takes its upper neighbour

    // ----------------------------------------------------------
    // per-slot update
    // ----------------------------------------------------------
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot

        // neighbour above, top slot points at itself
        localparam int UP = (i < DEPTH - 1) ? i + 1 : i;

        // with an issue the new entry lands one slot lower
        assign load_sel[i] = write_en && (shift ? fill_ptr[i+1] : fill_ptr[i]);

        // top slot has nothing above, it just goes invalid
        assign move_sel[i] = shift && (i < DEPTH - 1);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                slot_q[i] <= '0;
            end else if (load_sel[i]) begin
                slot_q[i] <= dispatch_payload;
            end else if (move_sel[i]) begin
                slot_q[i] <= slot_q[UP];   // compress toward head
            end
            // otherwise hold
        end

    end

    // ----------------------------------------------------------
    // head
    // ----------------------------------------------------------

    // straight from the register, valid only with entry_valid[0]
    assign head_payload = slot_q[0];

endmodule

//--- iq_operand_column.sv
`timescale 1ns/100ps

module iq_operand_column #(
    parameter int DEPTH  = iq_pkg::DEFAULT_DEPTH,
    parameter int NUM_WB = iq_pkg::DEFAULT_NUM_WB
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               write_en,
    input  logic                               shift,
    input  logic [DEPTH:0]                     fill_ptr,
    input  logic [DEPTH-1:0]                   entry_valid,
    input  iq_pkg::src_t                       src_in,
    input  iq_pkg::wb_bus_t [NUM_WB-1:0]       wb,
    output logic                               head_pending,
    output logic [iq_pkg::WORD_W-1:0]          head_value
);

    import iq_pkg::*;

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------
    src_t slot_q [DEPTH];     // pending, tag, value per slot

    wb_bus_t slot_wake [DEPTH];  // bus that wakes each stored operand
    wb_bus_t in_wake;            // bus that wakes the incoming operand
    src_t    in_src;             // incoming operand after wakeup

    logic [DEPTH-1:0] load_sel;
    logic [DEPTH-1:0] move_sel;

    // ----------------------------------------------------------
    // wakeup lookup
    // ----------------------------------------------------------

    // returns the matching bus, valid low if none
    function automatic wb_bus_t wake_lookup(
        input logic                  pending,
        input logic [TAG_W-1:0]      tag,
        input wb_bus_t [NUM_WB-1:0]  buses
    );
        wb_bus_t sel;
        sel = '0;
        // walk downward so the lowest index is applied last
        for (int b = NUM_WB - 1; b >= 0; b--) begin
            if (pending && buses[b].valid && (buses[b].tag == tag)) begin
                sel = buses[b];
            end
        end
        return sel;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_wake[i] = wake_lookup(entry_valid[i] && slot_q[i].pending,
                                       slot_q[i].tag, wb);
        end
    end

    // operand being dispatched this cycle can catch a broadcast too
    always_comb begin
        in_wake = wake_lookup(src_in.pending, src_in.tag, wb);
        in_src  = src_in;
        if (in_wake.valid) begin
            in_src.pending = 1'b0;
            in_src.value   = in_wake.data;
        end
    end

    // ----------------------------------------------------------
    // per-slot update
    // ----------------------------------------------------------
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot

        localparam int UP = (i < DEPTH - 1) ? i + 1 : i;

        logic wake_own;   // this slot woken, no shift
        logic wake_up;    // slot above woken and moving down

        assign load_sel[i] = write_en && (shift ? fill_ptr[i+1] : fill_ptr[i]);
        assign move_sel[i] = shift && (i < DEPTH - 1);

        assign wake_own = slot_wake[i].valid && !shift;
        assign wake_up  = slot_wake[UP].valid && move_sel[i];

        // wakeup and load never hit the same slot, load targets an empty one
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                slot_q[i] <= '0;
            end else if (wake_own) begin
                slot_q[i].pending <= 1'b0;
                slot_q[i].value   <= slot_wake[i].data;
            end else if (wake_up) begin
                slot_q[i].pending <= 1'b0;
                slot_q[i].tag     <= slot_q[UP].tag;
                slot_q[i].value   <= slot_wake[UP].data;
            end else if (load_sel[i]) begin
                slot_q[i] <= in_src;
            end else if (move_sel[i]) begin
                slot_q[i] <= slot_q[UP];
            end
        end

    end

    // ----------------------------------------------------------
    // head
    // ----------------------------------------------------------
    assign head_pending = slot_q[0].pending;   // registered
    assign head_value   = slot_q[0].value;

endmodule

//--- issue_queue.sv
`timescale 1ns/100ps

module issue_queue #(
    parameter int DEPTH  = iq_pkg::DEFAULT_DEPTH,
    parameter int NUM_WB = iq_pkg::DEFAULT_NUM_WB
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // dispatch from decode
    input  logic                          dispatch_valid,
    input  iq_pkg::payload_t              dispatch_payload,
    input  iq_pkg::src_t                  rs1_src,
    input  iq_pkg::src_t                  rs2_src,
    // writeback broadcasts
    input  iq_pkg::wb_bus_t [NUM_WB-1:0]  wb,
    // branch taken or exception
    input  logic                          flush,
    // functional unit side
    input  logic                          fu_ready,
    output logic                          issue_valid,
    output iq_pkg::issue_t                issue,
    output logic                          full
);

    import iq_pkg::*;

    // ----------------------------------------------------------
    // internal wires
    // ----------------------------------------------------------
    logic [DEPTH:0]    fill_ptr;
    logic [DEPTH-1:0]  entry_valid;
    logic              write_en;
    logic              shift;        // issue fire

    logic              head_pending_rs1;
    logic              head_pending_rs2;
    logic [WORD_W-1:0] head_value_rs1;
    logic [WORD_W-1:0] head_value_rs2;
    payload_t          head_payload;

    // ----------------------------------------------------------
    // occupancy and control
    // ----------------------------------------------------------
    iq_occupancy #(
        .DEPTH (DEPTH)
    ) i_occupancy (
        .clk              (clk),
        .rst_n            (rst_n),
        .dispatch_valid   (dispatch_valid),
        .flush            (flush),
        .fu_ready         (fu_ready),
        .head_pending_rs1 (head_pending_rs1),
        .head_pending_rs2 (head_pending_rs2),
        .fill_ptr         (fill_ptr),
        .entry_valid      (entry_valid),
        .write_en         (write_en),
        .shift            (shift),
        .full             (full)
    );

    // ----------------------------------------------------------
    // storage columns
    // ----------------------------------------------------------
    iq_payload_column #(
        .DEPTH (DEPTH)
    ) i_payload (
        .clk              (clk),
        .rst_n            (rst_n),
        .write_en         (write_en),
        .shift            (shift),
        .fill_ptr         (fill_ptr),
        .dispatch_payload (dispatch_payload),
        .head_payload     (head_payload)
    );

    iq_operand_column #(
        .DEPTH  (DEPTH),
        .NUM_WB (NUM_WB)
    ) i_rs1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_en     (write_en),
        .shift        (shift),
        .fill_ptr     (fill_ptr),
        .entry_valid  (entry_valid),
        .src_in       (rs1_src),
        .wb           (wb),
        .head_pending (head_pending_rs1),
        .head_value   (head_value_rs1)
    );

    iq_operand_column #(
        .DEPTH  (DEPTH),
        .NUM_WB (NUM_WB)
    ) i_rs2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_en     (write_en),
        .shift        (shift),
        .fill_ptr     (fill_ptr),
        .entry_valid  (entry_valid),
        .src_in       (rs2_src),
        .wb           (wb),
        .head_pending (head_pending_rs2),
        .head_value   (head_value_rs2)
    );

    // ----------------------------------------------------------
    // issue out, same cycle as the fire
    // ----------------------------------------------------------
    assign issue_valid = shift;

    always_comb begin
        issue.payload   = head_payload;
        issue.rs1_value = head_value_rs1;
        issue.rs2_value = head_value_rs2;
    end

endmodule

//--- tb_issue_queue_table.svh
// add_row(test, dispatch, dst, rs1, rs2, wb0, wb1, wb2, flush, fu_ready,
//         exp_issue, exp_dst, exp_rs1, exp_rs2, exp_full), rs 'hPTCC, wb 'hVTCC
test_name[1] = "back-to-back ready dispatch";
test_name[2] = "wakeup from writeback bus";
test_name[3] = "capture in dispatch cycle";
test_name[4] = "in-order issue and back-pressure";
test_name[5] = "full drops dispatch";
test_name[6] = "flush";

add_row(1, 1, 'h1, 'h0080, 'h0081, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(1, 1, 'h2, 'h0082, 'h0083, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h1, 'h80, 'h81, 0);
add_row(1, 1, 'h3, 'h0084, 'h0085, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h2, 'h82, 'h83, 0);
add_row(1, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h3, 'h84, 'h85, 0);
add_row(1, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);

add_row(2, 1, 'h4, 'h1500, 'h0086, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(2, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h1587, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(2, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h4, 'h87, 'h86, 0);
add_row(2, 1, 'h5, 'h0088, 'h1600, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(2, 0, 'h0, 'h0000, 'h0000, 'h1689, 'h0000, 'h168A, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(2, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h5, 'h88, 'h89, 0);

add_row(3, 1, 'h6, 'h1700, 'h008B, 'h0000, 'h178C, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(3, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h6, 'h8C, 'h8B, 0);
add_row(3, 1, 'h7, 'h1800, 'h1900, 'h198D, 'h0000, 'h188E, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(3, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h7, 'h8E, 'h8D, 0);

add_row(4, 1, 'h8, 'h1A00, 'h008F, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(4, 1, 'h9, 'h0090, 'h0091, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(4, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(4, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h1A92, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(4, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(4, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 2, 'h8, 'h92, 'h8F, 0);
add_row(4, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h9, 'h90, 'h91, 0);
add_row(4, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);

add_row(5, 1, 'h1, 'h0093, 'h0094, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(5, 1, 'h2, 'h0095, 'h0096, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(5, 1, 'h3, 'h0097, 'h0098, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(5, 1, 'h4, 'h0099, 'h009A, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(5, 1, 'h5, 'h009B, 'h009C, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 1);
add_row(5, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h1, 'h93, 'h94, 1);
add_row(5, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h2, 'h95, 'h96, 0);
add_row(5, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h3, 'h97, 'h98, 0);
add_row(5, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h4, 'h99, 'h9A, 0);
add_row(5, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);

add_row(6, 1, 'hC, 'h009D, 'h009E, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(6, 1, 'hD, 'h009F, 'h00A0, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(6, 1, 'hE, 'h00A1, 'h00A2, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(6, 1, 'hF, 'h00A3, 'h00A4, 'h0000, 'h0000, 'h0000, 0, 0, 0, 'h0, 'h00, 'h00, 0);
add_row(6, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 1, 1, 0, 'h0, 'h00, 'h00, 1);
add_row(6, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(6, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(6, 1, 'h3, 'h00A5, 'h00A6, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);
add_row(6, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 1, 'h3, 'hA5, 'hA6, 0);
add_row(6, 0, 'h0, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 1, 0, 'h0, 'h00, 'h00, 0);

//--- tb_issue_queue.sv
`timescale 1ns/100ps

module tb_issue_queue;

    import iq_pkg::*;

    localparam int DEPTH         = 4;
    localparam int NUM_WB        = 3;
    localparam int ISSUE_TIMEOUT = 8;    // cycles

    // one table row per cycle
    // operand and bus fields are 'hPTCC / 'hVTCC codes, decoded below
    typedef struct packed {
        logic [3:0]              test;
        logic                    dispatch;
        logic [3:0]              dst;
        logic [15:0]             rs1;
        logic [15:0]             rs2;
        logic [NUM_WB-1:0][15:0] wb;
        logic                    flush;
        logic                    fu_ready;
        logic [1:0]              exp_issue;  // 2 waits for the issue
        logic [3:0]              exp_dst;
        logic [7:0]              exp_rs1;
        logic [7:0]              exp_rs2;
        logic                    exp_full;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic                 dispatch_valid;
    payload_t             dispatch_payload;
    src_t                 rs1_src;
    src_t                 rs2_src;
    wb_bus_t [NUM_WB-1:0] wb;
    logic                 flush;
    logic                 fu_ready;
    logic                 issue_valid;
    issue_t               issue;
    logic                 full;

    row_t        rows[$];
    string       test_name [1:6];
    logic [31:0] pool [64];     // random operand words
    integer      seed;
    int          check_fails;

    issue_queue #(
        .DEPTH  (DEPTH),
        .NUM_WB (NUM_WB)
    ) i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .dispatch_valid   (dispatch_valid),
        .dispatch_payload (dispatch_payload),
        .rs1_src          (rs1_src),
        .rs2_src          (rs2_src),
        .wb               (wb),
        .flush            (flush),
        .fu_ready         (fu_ready),
        .issue_valid      (issue_valid),
        .issue            (issue),
        .full             (full)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------
    // table building and decoding
    // ----------------------------------------------------------
    task automatic add_row(
        input int test,
        input int dispatch,
        input int dst,
        input int rs1,
        input int rs2,
        input int wb0,
        input int wb1,
        input int wb2,
        input int do_flush,
        input int fu_rdy,
        input int exp_issue,
        input int exp_dst,
        input int exp_rs1,
        input int exp_rs2,
        input int exp_full
    );
        row_t r;
        r.test      = test[3:0];
        r.dispatch  = dispatch[0];
        r.dst       = dst[3:0];
        r.rs1       = rs1[15:0];
        r.rs2       = rs2[15:0];
        r.wb[0]     = wb0[15:0];
        r.wb[1]     = wb1[15:0];
        r.wb[2]     = wb2[15:0];
        r.flush     = do_flush[0];
        r.fu_ready  = fu_rdy[0];
        r.exp_issue = exp_issue[1:0];
        r.exp_dst   = exp_dst[3:0];
        r.exp_rs1   = exp_rs1[7:0];
        r.exp_rs2   = exp_rs2[7:0];
        r.exp_full  = exp_full[0];
        rows.push_back(r);
    endtask

    task automatic build_table();
        `include "tb_issue_queue_table.svh"
    endtask

    // 'h80+k picks random word k, lower codes stand for themselves
    function automatic logic [31:0] word_of(input logic [7:0] code);
        if (code[7]) begin
            return pool[code[5:0]];
        end
        return {24'h0, code};
    endfunction

    function automatic src_t src_of(input logic [15:0] code);
        src_t s;
        s.pending = code[12];
        s.tag     = code[11:8];
        s.value   = word_of(code[7:0]);
        return s;
    endfunction

    function automatic wb_bus_t bus_of(input logic [15:0] code);
        wb_bus_t b;
        b.valid = code[12];
        b.tag   = code[11:8];
        b.data  = word_of(code[7:0]);
        return b;
    endfunction

    // other payload fields follow from dst
    function automatic payload_t payload_of(input logic [3:0] dst);
        payload_t p;
        p.op  = {2'b01, dst};
        p.pc  = 32'h0000_1000 + {26'h0, dst, 2'b00};
        p.imm = {28'h0, dst};
        p.dst = dst;
        return p;
    endfunction

    // ----------------------------------------------------------
    // drive and check
    // ----------------------------------------------------------
    task automatic drive_row(input row_t r);
        dispatch_valid   = r.dispatch;
        dispatch_payload = payload_of(r.dst);
        rs1_src          = src_of(r.rs1);
        rs2_src          = src_of(r.rs2);
        for (int b = 0; b < NUM_WB; b++) begin
            wb[b] = bus_of(r.wb[b]);
        end
        flush    = r.flush;
        fu_ready = r.fu_ready;
    endtask

    task automatic drive_idle(input logic rdy);
        dispatch_valid   = 1'b0;
        dispatch_payload = '0;
        rs1_src          = '0;
        rs2_src          = '0;
        wb               = '0;
        flush            = 1'b0;
        fu_ready         = rdy;
    endtask

    task automatic check_row(input int idx, input row_t r);
        logic     exp_valid;
        payload_t exp_pl;
        exp_valid = (r.exp_issue != 2'd0);
        exp_pl    = payload_of(r.exp_dst);
        assert (issue_valid === exp_valid) else begin
            $display("Error at %0t: row %0d issue_valid %b, expected %b",
                     $time, idx, issue_valid, exp_valid);
            check_fails++;
        end
        assert (full === r.exp_full) else begin
            $display("Error at %0t: row %0d full %b, expected %b",
                     $time, idx, full, r.exp_full);
            check_fails++;
        end
        if (exp_valid && issue_valid === 1'b1) begin
            assert (issue.payload.dst === r.exp_dst) else begin
                $display("Error at %0t: row %0d issue dst %h, expected %h",
                         $time, idx, issue.payload.dst, r.exp_dst);
                check_fails++;
            end
            assert (issue.payload.op === exp_pl.op && issue.payload.pc === exp_pl.pc
                    && issue.payload.imm === exp_pl.imm) else begin
                $display("Error at %0t: row %0d issue op/pc/imm %h/%h/%h, expected %h/%h/%h",
                         $time, idx, issue.payload.op, issue.payload.pc, issue.payload.imm,
                         exp_pl.op, exp_pl.pc, exp_pl.imm);
                check_fails++;
            end
            assert (issue.rs1_value === word_of(r.exp_rs1)) else begin
                $display("Error at %0t: row %0d rs1 value %h, expected %h",
                         $time, idx, issue.rs1_value, word_of(r.exp_rs1));
                check_fails++;
            end
            assert (issue.rs2_value === word_of(r.exp_rs2)) else begin
                $display("Error at %0t: row %0d rs2 value %h, expected %h",
                         $time, idx, issue.rs2_value, word_of(r.exp_rs2));
                check_fails++;
            end
        end
    endtask

    // row inputs go in for one cycle only, then idle until the issue
    task automatic wait_issue(input int idx, input row_t r);
        int waited;
        waited = 0;
        while (issue_valid !== 1'b1 && waited < ISSUE_TIMEOUT) begin
            @(posedge clk);
            #1 drive_idle(r.fu_ready);
            #7;
            waited++;
        end
        if (issue_valid !== 1'b1) begin
            $display("row %0d: timed out, no issue within %0d cycles", idx, ISSUE_TIMEOUT);
            check_fails++;
        end else begin
            check_row(idx, r);
        end
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        int   fails_before;
        int   tests_run;
        int   tests_failed;
        row_t r;
        logic last;

        $timeformat(-9, 1, " ns", 0);
        seed         = 32'h22f4_72c7;
        check_fails  = 0;
        fails_before = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        drive_idle(1'b0);
        for (int k = 0; k < 64; k++) begin
            pool[k] = $random(seed);
        end
        build_table();

        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int idx = 0; idx < rows.size(); idx++) begin
            r = rows[idx];
            @(posedge clk);
            #1 drive_row(r);
            #7;                        // settled, 2 ns before the edge
            if (r.exp_issue == 2'd2) begin
                wait_issue(idx, r);
            end else begin
                check_row(idx, r);
            end

            last = 1'b1;
            if (idx < rows.size() - 1) begin
                last = (rows[idx + 1].test != r.test);
            end
            if (last) begin
                tests_run++;
                if (check_fails == fails_before) begin
                    $display("test %0d (%s): passed", r.test, test_name[r.test]);
                end else begin
                    $display("test %0d (%s): failed, %0d bad checks",
                             r.test, test_name[r.test], check_fails - fails_before);
                    tests_failed++;
                end
                fails_before = check_fails;
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, failing checks %0d",
                 tests_run, tests_run - tests_failed, tests_failed, check_fails);
        if (check_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
iq_pkg.sv
iq_occupancy.sv
iq_payload_column.sv
iq_operand_column.sv
issue_queue.sv
tb_issue_queue.sv

//--- run.sh
#!/usr/bin/env bash
# build the issue queue testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=tb_issue_queue

verilator --binary --assert --top-module tb_issue_queue \
    -f src.f -Mdir "$BUILD_DIR" -o "$SIM_BIN" > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the verdict comes from the log alone
if grep -qx "STATUS: PASS" "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $SIM_LOG"
exit 1
